//--- cache_sys_macros.svh
`ifndef CACHE_SYS_MACROS_SVH
`define CACHE_SYS_MACROS_SVH

// word addressed, so one address per 32-bit word
`define CACHE_ADDR_W 16
`define CACHE_DATA_W 32

`define CACHE_IDX_W 4
`define CACHE_LINES (1 << `CACHE_IDX_W)
// the top address bit picks the control region and is not part of the tag
`define CACHE_TAG_W (`CACHE_ADDR_W - `CACHE_IDX_W - 1)

`define CACHE_OFS_W 3

// control region offsets
`define CACHE_RW_HIT_OFS     3'd0
`define CACHE_RW_MISS_OFS    3'd1
`define CACHE_READ_HIT_OFS   3'd2
`define CACHE_READ_MISS_OFS  3'd3
`define CACHE_WRITE_HIT_OFS  3'd4
`define CACHE_WRITE_MISS_OFS 3'd5
`define CACHE_RST_CNT_OFS    3'd6
`define CACHE_INVALIDATE_OFS 3'd7

// returned at any control address with bits set above the offset
`define CACHE_VERSION 32'h0001_0200

`endif

//--- cache_sys_pkg.sv
`include "cache_sys_macros.svh"

package cache_sys_pkg;

  typedef logic [`CACHE_ADDR_W-1:0] addr_t;
  typedef logic [`CACHE_DATA_W-1:0] data_t; // also the counter width
  typedef logic [`CACHE_IDX_W-1:0] idx_t;
  typedef logic [`CACHE_TAG_W-1:0] tag_t;
  typedef logic [`CACHE_OFS_W-1:0] ofs_t;

  typedef enum logic [1:0] {
    core_idle,
    core_lookup,
    core_fetch,
    core_write_thru
  } core_state_t;

  // which target the front is waiting on
  typedef enum logic [1:0] {
    front_idle,
    front_wait_core,
    front_wait_ctrl
  } front_state_t;

endpackage

//--- cache_front.sv
`timescale 1ns/100ps
`include "cache_sys_macros.svh"

module cache_front (
  input  logic                 clk_i,
  input  logic                 arst_i,
  input  logic                 req_i,
  input  logic                 we_i,
  input  cache_sys_pkg::addr_t addr_i,
  input  cache_sys_pkg::data_t wdata_i,
  input  logic                 core_ack_i,
  input  cache_sys_pkg::data_t core_rdata_i,
  input  logic                 ctrl_ack_i,
  input  cache_sys_pkg::data_t ctrl_rdata_i,
  output logic                 ack_o,
  output cache_sys_pkg::data_t rdata_o,
  output logic                 core_req_o,
  output logic                 core_we_o,
  output cache_sys_pkg::addr_t core_addr_o,
  output cache_sys_pkg::data_t core_wdata_o,
  output logic                 ctrl_req_o,
  output cache_sys_pkg::addr_t ctrl_addr_o
);
  import cache_sys_pkg::*;

  front_state_t state_q;
  addr_t        addr_q;
  logic         ctrl_sel;
  logic         accept;

  assign ctrl_sel = addr_i[`CACHE_ADDR_W-1]; // region bit is only decoded here
  assign accept   = req_i && (state_q == front_idle);

  assign core_addr_o = addr_q;
  assign ctrl_addr_o = addr_q;

  always_ff @(posedge clk_i or posedge arst_i) begin
    if (arst_i) begin
      state_q    <= front_idle;
      core_req_o <= 1'b0;
      ctrl_req_o <= 1'b0;
      ack_o      <= 1'b0;
      rdata_o    <= '0;
    end else begin
      core_req_o <= 1'b0;
      ctrl_req_o <= 1'b0;
      ack_o      <= 1'b0;
      case (state_q)
        front_idle: begin
          if (accept) begin
            if (ctrl_sel) begin
              ctrl_req_o <= 1'b1;
              state_q    <= front_wait_ctrl;
            end else begin
              core_req_o <= 1'b1;
              state_q    <= front_wait_core;
            end
          end
        end
        front_wait_core: begin
          if (core_ack_i) begin
            ack_o   <= 1'b1;
            rdata_o <= core_we_o ? '0 : core_rdata_i; // writes answer zero
            state_q <= front_idle;
          end
        end
        front_wait_ctrl: begin
          if (ctrl_ack_i) begin
            ack_o   <= 1'b1;
            rdata_o <= ctrl_rdata_i;
            state_q <= front_idle;
          end
        end
        default: state_q <= front_idle;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      core_we_o    <= we_i;
      addr_q       <= addr_i;
      core_wdata_o <= wdata_i;
    end
  end

endmodule

//--- cache_core.sv
`timescale 1ns/100ps
`include "cache_sys_macros.svh"

module cache_core (
  input  logic                 clk_i,
  input  logic                 arst_i,
  input  logic                 core_req_i,
  input  logic                 core_we_i,
  input  cache_sys_pkg::addr_t core_addr_i,
  input  cache_sys_pkg::data_t core_wdata_i,
  input  logic                 invalidate_i,
  input  logic                 mp_done_i,
  input  cache_sys_pkg::data_t mp_rdata_i,
  output logic                 core_ack_o,
  output cache_sys_pkg::data_t core_rdata_o,
  output logic                 read_hit_o,
  output logic                 read_miss_o,
  output logic                 write_hit_o,
  output logic                 write_miss_o,
  output logic                 mp_req_o,
  output logic                 mp_we_o,
  output cache_sys_pkg::addr_t mp_addr_o,
  output cache_sys_pkg::data_t mp_wdata_o
);
  import cache_sys_pkg::*;

  core_state_t state_q;

  logic [`CACHE_LINES-1:0] valid_q;
  tag_t                    tag_mem [`CACHE_LINES];
  data_t                   data_mem [`CACHE_LINES];

  idx_t req_idx;
  tag_t req_tag;
  idx_t fill_idx;
  tag_t fill_tag;
  logic hit;
  logic accept;
  logic fill;

  assign req_idx = core_addr_i[`CACHE_IDX_W-1:0];
  assign req_tag = core_addr_i[`CACHE_ADDR_W-2:`CACHE_IDX_W];

  // the pending request address doubles as the fill address
  assign fill_idx = mp_addr_o[`CACHE_IDX_W-1:0];
  assign fill_tag = mp_addr_o[`CACHE_ADDR_W-2:`CACHE_IDX_W];

  assign hit    = valid_q[req_idx] && (tag_mem[req_idx] == req_tag);
  assign accept = core_req_i && (state_q == core_idle);
  assign fill   = mp_done_i && (state_q == core_fetch);

  always_ff @(posedge clk_i or posedge arst_i) begin
    if (arst_i) begin
      state_q      <= core_idle;
      core_ack_o   <= 1'b0;
      mp_req_o     <= 1'b0;
      mp_we_o      <= 1'b0;
      read_hit_o   <= 1'b0;
      read_miss_o  <= 1'b0;
      write_hit_o  <= 1'b0;
      write_miss_o <= 1'b0;
    end else begin
      core_ack_o   <= 1'b0;
      mp_req_o     <= 1'b0;
      read_hit_o   <= 1'b0;
      read_miss_o  <= 1'b0;
      write_hit_o  <= 1'b0;
      write_miss_o <= 1'b0;
      case (state_q)
        core_idle: begin
          if (accept) begin
            // exactly one event per access, flagged as the tags are compared
            read_hit_o   <= !core_we_i && hit;
            read_miss_o  <= !core_we_i && !hit;
            write_hit_o  <= core_we_i && hit;
            write_miss_o <= core_we_i && !hit;
            if (!core_we_i && hit) begin
              core_ack_o <= 1'b1;
            end else begin
              mp_req_o <= 1'b1;
              mp_we_o  <= core_we_i;
              state_q  <= core_lookup;
            end
          end
        end
        // mp_req_o is high in this cycle
        core_lookup: state_q <= mp_we_o ? core_write_thru : core_fetch;
        core_fetch: begin
          if (mp_done_i) begin
            core_ack_o <= 1'b1;
            state_q    <= core_idle;
          end
        end
        core_write_thru: begin
          if (mp_done_i) begin
            core_ack_o <= 1'b1;
            state_q    <= core_idle;
          end
        end
        default: state_q <= core_idle;
      endcase
    end
  end

  always_ff @(posedge clk_i or posedge arst_i) begin
    if (arst_i) begin
      valid_q <= '0;
    end else if (invalidate_i) begin
      valid_q <= '0;
    end else if (fill) begin
      valid_q[fill_idx] <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      mp_addr_o  <= core_addr_i;
      mp_wdata_o <= core_wdata_i;
      if (hit) begin
        if (core_we_i) begin
          data_mem[req_idx] <= core_wdata_i; // memory still gets the write
        end else begin
          core_rdata_o <= data_mem[req_idx];
        end
      end
    end
    if (fill) begin
      tag_mem[fill_idx]  <= fill_tag;
      data_mem[fill_idx] <= mp_rdata_i;
      core_rdata_o       <= mp_rdata_i;
    end
  end

endmodule

//--- cache_ctrl.sv
`timescale 1ns/100ps
`include "cache_sys_macros.svh"

module cache_ctrl (
  input  logic                 clk_i,
  input  logic                 arst_i,
  input  logic                 ctrl_req_i,
  input  cache_sys_pkg::addr_t ctrl_addr_i,
  input  logic                 read_hit_i,
  input  logic                 read_miss_i,
  input  logic                 write_hit_i,
  input  logic                 write_miss_i,
  output logic                 ctrl_ack_o,
  output cache_sys_pkg::data_t ctrl_rdata_o,
  output logic                 invalidate_o
);
  import cache_sys_pkg::*;

  data_t rd_hit_cnt;
  data_t rd_miss_cnt;
  data_t wr_hit_cnt;
  data_t wr_miss_cnt;
  data_t hit_sum;
  data_t miss_sum;
  data_t view;
  ofs_t  ofs;
  logic  upper_zero;
  logic  clear_cnt;

  assign ofs        = ctrl_addr_i[`CACHE_OFS_W-1:0];
  assign upper_zero = (ctrl_addr_i[`CACHE_ADDR_W-2:`CACHE_OFS_W] == '0);
  assign clear_cnt  = ctrl_req_i && upper_zero && (ofs == `CACHE_RST_CNT_OFS);

  assign hit_sum  = rd_hit_cnt + wr_hit_cnt;
  assign miss_sum = rd_miss_cnt + wr_miss_cnt;

  // counters wrap, and a clear never meets an event since only one request is in flight
  always_ff @(posedge clk_i or posedge arst_i) begin
    if (arst_i) begin
      rd_hit_cnt  <= '0;
      rd_miss_cnt <= '0;
      wr_hit_cnt  <= '0;
      wr_miss_cnt <= '0;
    end else if (clear_cnt) begin
      rd_hit_cnt  <= '0;
      rd_miss_cnt <= '0;
      wr_hit_cnt  <= '0;
      wr_miss_cnt <= '0;
    end else begin
      if (read_hit_i) rd_hit_cnt <= rd_hit_cnt + 1'b1;
      if (read_miss_i) rd_miss_cnt <= rd_miss_cnt + 1'b1;
      if (write_hit_i) wr_hit_cnt <= wr_hit_cnt + 1'b1;
      if (write_miss_i) wr_miss_cnt <= wr_miss_cnt + 1'b1;
    end
  end

  always_comb begin
    view = `CACHE_VERSION;
    if (upper_zero) begin
      case (ofs)
        `CACHE_RW_HIT_OFS:     view = hit_sum;
        `CACHE_RW_MISS_OFS:    view = miss_sum;
        `CACHE_READ_HIT_OFS:   view = rd_hit_cnt;
        `CACHE_READ_MISS_OFS:  view = rd_miss_cnt;
        `CACHE_WRITE_HIT_OFS:  view = wr_hit_cnt;
        `CACHE_WRITE_MISS_OFS: view = wr_miss_cnt;
        default:               view = '0; // the two actions read as zero
      endcase
    end
  end

  always_ff @(posedge clk_i or posedge arst_i) begin
    if (arst_i) begin
      ctrl_ack_o   <= 1'b0;
      invalidate_o <= 1'b0;
    end else begin
      ctrl_ack_o   <= ctrl_req_i;
      invalidate_o <= ctrl_req_i && upper_zero && (ofs == `CACHE_INVALIDATE_OFS);
    end
  end

  always_ff @(posedge clk_i) begin
    if (ctrl_req_i) ctrl_rdata_o <= view;
  end

endmodule

//--- cache_mem_port.sv
`timescale 1ns/100ps

module cache_mem_port (
  input  logic                 clk_i,
  input  logic                 arst_i,
  input  logic                 mp_req_i,
  input  logic                 mp_we_i,
  input  cache_sys_pkg::addr_t mp_addr_i,
  input  cache_sys_pkg::data_t mp_wdata_i,
  input  logic                 mem_ack_i,
  input  cache_sys_pkg::data_t mem_rdata_i,
  output logic                 mp_done_o,
  output cache_sys_pkg::data_t mp_rdata_o,
  output logic                 mem_req_o,
  output logic                 mem_we_o,
  output cache_sys_pkg::addr_t mem_addr_o,
  output cache_sys_pkg::data_t mem_wdata_o
);
  import cache_sys_pkg::*;

  logic mem_done;

  // an ack only counts while a request is on the pins
  assign mem_done = mem_req_o && mem_ack_i;

  always_ff @(posedge clk_i or posedge arst_i) begin
    if (arst_i) begin
      mem_req_o <= 1'b0;
      mem_we_o  <= 1'b0;
      mp_done_o <= 1'b0;
    end else begin
      mp_done_o <= mem_done;
      if (mp_req_i) begin
        mem_req_o <= 1'b1;
        mem_we_o  <= mp_we_i;
      end else if (mem_done) begin
        mem_req_o <= 1'b0;
        mem_we_o  <= 1'b0;
      end
    end
  end

  // address and data stay stable for as long as the request is held
  always_ff @(posedge clk_i) begin
    if (mp_req_i) begin
      mem_addr_o  <= mp_addr_i;
      mem_wdata_o <= mp_wdata_i;
    end
    if (mem_done) begin
      mp_rdata_o <= mem_rdata_i;
    end
  end

endmodule

//--- cache_sys_top.sv
`timescale 1ns/100ps

module cache_sys_top (
  input  logic                 clk_i,
  input  logic                 arst_i,
  input  logic                 req_i,
  input  logic                 we_i,
  input  cache_sys_pkg::addr_t addr_i,
  input  cache_sys_pkg::data_t wdata_i,
  output logic                 ack_o,
  output cache_sys_pkg::data_t rdata_o,
  output logic                 mem_req_o,
  output logic                 mem_we_o,
  output cache_sys_pkg::addr_t mem_addr_o,
  output cache_sys_pkg::data_t mem_wdata_o,
  input  logic                 mem_ack_i,
  input  cache_sys_pkg::data_t mem_rdata_i
);
  import cache_sys_pkg::*;

  logic  core_req;
  logic  core_we;
  addr_t core_addr;
  data_t core_wdata;
  logic  core_ack;
  data_t core_rdata;
  logic  ctrl_req;
  addr_t ctrl_addr;
  logic  ctrl_ack;
  data_t ctrl_rdata;
  logic  read_hit;
  logic  read_miss;
  logic  write_hit;
  logic  write_miss;
  logic  invalidate;
  logic  mp_req;
  logic  mp_we;
  addr_t mp_addr;
  data_t mp_wdata;
  logic  mp_done;
  data_t mp_rdata;

  cache_front u_front (
    .clk_i        (clk_i),
    .arst_i       (arst_i),
    .req_i        (req_i),
    .we_i         (we_i),
    .addr_i       (addr_i),
    .wdata_i      (wdata_i),
    .core_ack_i   (core_ack),
    .core_rdata_i (core_rdata),
    .ctrl_ack_i   (ctrl_ack),
    .ctrl_rdata_i (ctrl_rdata),
    .ack_o        (ack_o),
    .rdata_o      (rdata_o),
    .core_req_o   (core_req),
    .core_we_o    (core_we),
    .core_addr_o  (core_addr),
    .core_wdata_o (core_wdata),
    .ctrl_req_o   (ctrl_req),
    .ctrl_addr_o  (ctrl_addr)
  );

  cache_core u_core (
    .clk_i        (clk_i),
    .arst_i       (arst_i),
    .core_req_i   (core_req),
    .core_we_i    (core_we),
    .core_addr_i  (core_addr),
    .core_wdata_i (core_wdata),
    .invalidate_i (invalidate),
    .mp_done_i    (mp_done),
    .mp_rdata_i   (mp_rdata),
    .core_ack_o   (core_ack),
    .core_rdata_o (core_rdata),
    .read_hit_o   (read_hit),
    .read_miss_o  (read_miss),
    .write_hit_o  (write_hit),
    .write_miss_o (write_miss),
    .mp_req_o     (mp_req),
    .mp_we_o      (mp_we),
    .mp_addr_o    (mp_addr),
    .mp_wdata_o   (mp_wdata)
  );

  cache_ctrl u_ctrl (
    .clk_i        (clk_i),
    .arst_i       (arst_i),
    .ctrl_req_i   (ctrl_req),
    .ctrl_addr_i  (ctrl_addr),
    .read_hit_i   (read_hit),
    .read_miss_i  (read_miss),
    .write_hit_i  (write_hit),
    .write_miss_i (write_miss),
    .ctrl_ack_o   (ctrl_ack),
    .ctrl_rdata_o (ctrl_rdata),
    .invalidate_o (invalidate)
  );

  cache_mem_port u_mem_port (
    .clk_i       (clk_i),
    .arst_i      (arst_i),
    .mp_req_i    (mp_req),
    .mp_we_i     (mp_we),
    .mp_addr_i   (mp_addr),
    .mp_wdata_i  (mp_wdata),
    .mem_ack_i   (mem_ack_i),
    .mem_rdata_i (mem_rdata_i),
    .mp_done_o   (mp_done),
    .mp_rdata_o  (mp_rdata),
    .mem_req_o   (mem_req_o),
    .mem_we_o    (mem_we_o),
    .mem_addr_o  (mem_addr_o),
    .mem_wdata_o (mem_wdata_o)
  );

endmodule

//--- tb_cache_sys.sv
`timescale 1ns/100ps
`include "cache_sys_macros.svh"

module tb_cache_sys;
  import cache_sys_pkg::*;

  localparam int reset_cycles    = 16;
  localparam int worst_latency   = 16;
  localparam int random_accesses = 300;
  // random run, three view sweeps, counter reset, invalidate sequence, two version reads
  localparam int num_accesses    = random_accesses + 18 + 1 + 14 + 2;
  localparam int cycle_limit     = num_accesses * worst_latency + reset_cycles;
  localparam int mem_words       = 1 << (`CACHE_ADDR_W - 1);

  logic  clk_i = 1'b0;
  logic  arst_i;
  logic  req_i;
  logic  we_i;
  addr_t addr_i;
  data_t wdata_i;
  logic  ack_o;
  data_t rdata_o;
  logic  mem_req_o;
  logic  mem_we_o;
  addr_t mem_addr_o;
  data_t mem_wdata_o;
  logic  mem_ack_i;
  data_t mem_rdata_i;

  logic [31:0] lfsr = 32'h510f;
  int          cycle_cnt = 0;

  data_t mem_array [mem_words]; // what the memory responder serves
  data_t ref_mem [mem_words];   // model copy, only written by the model
  logic  mvalid [`CACHE_LINES];
  tag_t  mtag [`CACHE_LINES];
  data_t mdata [`CACHE_LINES];
  data_t rd_hits;
  data_t rd_misses;
  data_t wr_hits;
  data_t wr_misses;

  logic  mem_busy = 1'b0;
  int    mem_wait = 0;
  int    next_delay = 0;
  int    mem_reads = 0;
  int    mem_writes = 0;
  int    mem_raises = 0;
  addr_t last_addr;
  data_t last_wdata;

  cache_sys_top dut (
    .clk_i       (clk_i),
    .arst_i      (arst_i),
    .req_i       (req_i),
    .we_i        (we_i),
    .addr_i      (addr_i),
    .wdata_i     (wdata_i),
    .ack_o       (ack_o),
    .rdata_o     (rdata_o),
    .mem_req_o   (mem_req_o),
    .mem_we_o    (mem_we_o),
    .mem_addr_o  (mem_addr_o),
    .mem_wdata_o (mem_wdata_o),
    .mem_ack_i   (mem_ack_i),
    .mem_rdata_i (mem_rdata_i)
  );

  always #50 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt > cycle_limit) begin
      $display("timeout: no answer from the DUT within %0d cycles", cycle_limit);
      $display("sim failed");
      $fatal(1, "timeout");
    end
  end

  // memory responder, acks each held request after the delay picked for that access
  always @(posedge clk_i) begin
    mem_ack_i <= 1'b0;
    if (mem_busy) begin
      if (mem_wait == 0) begin
        mem_ack_i <= 1'b1;
        mem_busy = 1'b0;
        if (mem_we_o) begin
          mem_array[mem_addr_o[`CACHE_ADDR_W-2:0]] = mem_wdata_o;
        end
      end else begin
        mem_wait = mem_wait - 1;
      end
    end else if (mem_req_o && !mem_ack_i) begin
      mem_busy = 1'b1;
      mem_wait = next_delay;
      mem_raises = mem_raises + 1;
      last_addr = mem_addr_o;
      last_wdata = mem_wdata_o;
      if (mem_we_o) mem_writes = mem_writes + 1;
      else mem_reads = mem_reads + 1;
      mem_rdata_i <= mem_array[mem_addr_o[`CACHE_ADDR_W-2:0]];
    end
  end

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) return (s >> 1) ^ 32'h8020_0003;
    return s >> 1;
  endfunction

  // one LFSR step per bit taken
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int k = 0; k < n; k++) begin
      r = {r[30:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
    return r;
  endfunction

  function automatic addr_t control_addr(input ofs_t ofs);
    return {1'b1, {(`CACHE_ADDR_W-1-`CACHE_OFS_W){1'b0}}, ofs};
  endfunction

  task automatic check_data(input string name, input data_t exp, input data_t act);
    if (exp !== act) begin
      $display("Fail %s expected %h actual %h", name, exp, act);
      $display("sim failed");
      $fatal(1, "data mismatch in %s", name);
    end
  endtask

  task automatic check_addr(input string name, input addr_t exp, input addr_t act);
    if (exp !== act) begin
      $display("Fail %s expected %h actual %h", name, exp, act);
      $display("sim failed");
      $fatal(1, "address mismatch in %s", name);
    end
  endtask

  task automatic check_latency(input string name, input int exp, input int act);
    if (exp != act) begin
      $display("Fail %s expected %0d actual %0d", name, exp, act);
      $display("sim failed");
      $fatal(1, "latency mismatch in %s", name);
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (exp != act) begin
      $display("Fail %s expected %0d actual %0d", name, exp, act);
      $display("sim failed");
      $fatal(1, "count mismatch in %s", name);
    end
  endtask

  // lat counts rising edges from the one that samples req_i to the one that raises ack_o
  task automatic issue(input logic we, input addr_t addr, input data_t wdata,
                       output data_t rdata, output int lat);
    next_delay = int'(take_bits(3));
    @(posedge clk_i);
    req_i   <= 1'b1;
    we_i    <= we;
    addr_i  <= addr;
    wdata_i <= wdata;
    @(posedge clk_i);
    req_i <= 1'b0;
    lat = 1; // this edge samples req_i and is the first one counted
    @(negedge clk_i);
    while (!ack_o) begin
      @(posedge clk_i);
      lat = lat + 1;
      @(negedge clk_i);
    end
    rdata = rdata_o;
  endtask

  task automatic data_access(input logic we, input addr_t addr, input data_t wdata);
    idx_t  idx;
    tag_t  tag;
    logic  hit;
    data_t rdata;
    int    lat;
    int    reads_before;
    int    writes_before;
    int    raises_before;
    idx = addr[`CACHE_IDX_W-1:0];
    tag = addr[`CACHE_ADDR_W-2:`CACHE_IDX_W];
    hit = mvalid[idx] && (mtag[idx] == tag);
    reads_before  = mem_reads;
    writes_before = mem_writes;
    raises_before = mem_raises;
    issue(we, addr, wdata, rdata, lat);
    if (we) begin
      check_data("write rdata", '0, rdata);
      check_count("write memory writes", 1, mem_writes - writes_before);
      check_count("write memory reads", 0, mem_reads - reads_before);
      check_addr("write address", addr, last_addr);
      check_data("write data", wdata, last_wdata);
      ref_mem[addr[`CACHE_ADDR_W-2:0]] = wdata;
      if (hit) begin
        mdata[idx] = wdata; // write hit refreshes the line, a miss leaves it alone
        wr_hits = wr_hits + 32'd1;
      end else begin
        wr_misses = wr_misses + 32'd1;
      end
    end else if (hit) begin
      check_data("read hit data", mdata[idx], rdata);
      check_latency("read hit latency", 3, lat);
      check_count("read hit memory requests", 0, mem_raises - raises_before);
      rd_hits = rd_hits + 32'd1;
    end else begin
      check_data("read miss data", ref_mem[addr[`CACHE_ADDR_W-2:0]], rdata);
      check_count("read miss memory reads", 1, mem_reads - reads_before);
      check_count("read miss memory writes", 0, mem_writes - writes_before);
      check_addr("read miss address", addr, last_addr);
      mvalid[idx] = 1'b1;
      mtag[idx]   = tag;
      mdata[idx]  = ref_mem[addr[`CACHE_ADDR_W-2:0]];
      rd_misses = rd_misses + 32'd1;
    end
  endtask

  task automatic ctrl_read(input string name, input addr_t addr, input data_t exp);
    data_t rdata;
    int    lat;
    int    raises_before;
    raises_before = mem_raises;
    issue(1'b0, addr, '0, rdata, lat);
    check_data(name, exp, rdata);
    check_latency({name, " latency"}, 3, lat);
    check_count({name, " memory requests"}, 0, mem_raises - raises_before);
  endtask

  task automatic check_views();
    ctrl_read("read hit view", control_addr(`CACHE_READ_HIT_OFS), rd_hits);
    ctrl_read("read miss view", control_addr(`CACHE_READ_MISS_OFS), rd_misses);
    ctrl_read("write hit view", control_addr(`CACHE_WRITE_HIT_OFS), wr_hits);
    ctrl_read("write miss view", control_addr(`CACHE_WRITE_MISS_OFS), wr_misses);
    ctrl_read("combined hit view", control_addr(`CACHE_RW_HIT_OFS), rd_hits + wr_hits);
    ctrl_read("combined miss view", control_addr(`CACHE_RW_MISS_OFS), rd_misses + wr_misses);
  endtask

  initial begin
    logic  we;
    addr_t a;
    data_t wd;
    addr_t warm [4];
    arst_i      = 1'b1;
    req_i       = 1'b0;
    we_i        = 1'b0;
    addr_i      = '0;
    wdata_i     = '0;
    mem_ack_i   = 1'b0;
    mem_rdata_i = '0;
    rd_hits     = '0;
    rd_misses   = '0;
    wr_hits     = '0;
    wr_misses   = '0;
    for (int i = 0; i < mem_words; i++) begin
      mem_array[i] = (i * 32'h9e37_79b1) ^ 32'h5a5a_a5a5; // every address gets its own word
      ref_mem[i]   = mem_array[i];
    end
    for (int i = 0; i < `CACHE_LINES; i++) begin
      mvalid[i] = 1'b0;
      mtag[i]   = '0;
      mdata[i]  = '0;
    end
    repeat (reset_cycles) @(posedge clk_i);
    arst_i <= 1'b0;

    // few tags per index so that hits are common
    for (int n = 0; n < random_accesses; n++) begin
      we = (take_bits(2) == 0);
      a  = {1'b0, tag_t'(take_bits(2)), idx_t'(take_bits(4))};
      wd = take_bits(32);
      data_access(we, a, wd);
    end
    check_views();

    ctrl_read("counter reset", control_addr(`CACHE_RST_CNT_OFS), '0);
    rd_hits   = '0;
    rd_misses = '0;
    wr_hits   = '0;
    wr_misses = '0;
    check_views();

    warm[0] = 16'h0123;
    warm[1] = 16'h0456;
    warm[2] = 16'h07a9;
    warm[3] = 16'h0fcf;
    for (int k = 0; k < 4; k++) data_access(1'b0, warm[k], '0);
    for (int k = 0; k < 4; k++) data_access(1'b0, warm[k], '0);
    ctrl_read("invalidate", control_addr(`CACHE_INVALIDATE_OFS), '0);
    for (int i = 0; i < `CACHE_LINES; i++) mvalid[i] = 1'b0;
    data_access(1'b1, warm[0], take_bits(32));
    for (int k = 0; k < 4; k++) data_access(1'b0, warm[k], '0);
    check_views();

    ctrl_read("version low", 16'h8008, `CACHE_VERSION);
    ctrl_read("version high", 16'hfff5, `CACHE_VERSION);

    $display("sim passed");
    $finish;
  end

endmodule

//--- cache_sys.f
+incdir+.
cache_sys_pkg.sv
cache_front.sv
cache_core.sv
cache_ctrl.sv
cache_mem_port.sv
cache_sys_top.sv
tb_cache_sys.sv

//--- run_sim.sh
#!/bin/sh
# build and run the cache_sys testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary -Wno-fatal --top-module tb_cache_sys -f cache_sys.f -o tb_cache_sys
if [ $? -ne 0 ]; then
  echo "verilator compile failed"
  exit 1
fi

./obj_dir/tb_cache_sys > "$log" 2>&1
status=$?
cat "$log"

if grep -q "sim failed" "$log"; then
  echo "testbench reported a failure, see $log"
  exit 1
fi
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi
if ! grep -q "sim passed" "$log"; then
  echo "simulation ended without a result line"
  exit 1
fi
exit 0
